// ==== src/hmr_macros.svh ====
// Fixed six cores in two groups of three, word-addressed register map with 6-bit word index
`ifndef HMR_MACROS_SVH
`define HMR_MACROS_SVH

`define HMR_NUM_CORES  6
`define HMR_NUM_GROUPS 2
`define HMR_ADDR_W     32
`define HMR_DATA_W     32
`define HMR_REG_AW     6
`define HMR_MODE_W     2

// Group modes
`define HMR_MODE_NON    2'd0
`define HMR_MODE_RUN    2'd1
`define HMR_MODE_UNLOAD 2'd2
`define HMR_MODE_RELOAD 2'd3

// Register word addresses
`define HMR_ADDR_CFG(g)   (2 * (g))
`define HMR_ADDR_STORE(g) (2 * (g) + 1)
`define HMR_ADDR_MISM(c)  (16 + (c))

// busy, instr req, instr addr, data req, data addr, write enable, write data
`define HMR_VOTE_W (1 + 1 + `HMR_ADDR_W + 1 + `HMR_ADDR_W + 1 + `HMR_DATA_W)

`endif

// ==== src/hmr_pkg.sv ====
// Sequential grouping only: group g holds cores 3g to 3g+2 and core 3g leads
package hmr_pkg;

  // Group configuration word, raw for the bus, fields for the mode FSM
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [26:0] reserved;
      logic        force_resynch;
      logic        reload_setback;
      logic        setback;
      logic        delay_resynch;
      logic        tmr_enable;
    } f;
  } tmr_cfg_u;

  function automatic int group_of(int core);
    return core / 3;
  endfunction

  function automatic int core_of(int group, int offset);
    return group * 3 + offset;
  endfunction

endpackage

// ==== src/hmr_tmr_voter.sv ====
// Combinational only; failure is flagged when all three words differ pairwise
`include "hmr_macros.svh"

module hmr_voter (
  input  logic [`HMR_VOTE_W-1:0] a_i,
  input  logic [`HMR_VOTE_W-1:0] b_i,
  input  logic [`HMR_VOTE_W-1:0] c_i,
  output logic [`HMR_VOTE_W-1:0] majority_o,
  output logic [2:0]             error_cba_o,
  output logic                   failure_o
);

  logic [`HMR_VOTE_W-1:0] majority;
  logic                   ab_eq;
  logic                   bc_eq;
  logic                   ac_eq;

  // Two of three per bit
  assign majority = (a_i & b_i) | (b_i & c_i) | (a_i & c_i);

  assign ab_eq = (a_i == b_i);
  assign bc_eq = (b_i == c_i);
  assign ac_eq = (a_i == c_i);

  assign majority_o  = majority;
  assign error_cba_o = {c_i != majority, b_i != majority, a_i != majority};
  assign failure_o   = !(ab_eq || bc_eq || ac_eq);

endmodule

// ==== src/hmr_mode_ctrl.sv ====
// One group; the mode changes at the edge after its cause and setback is a one-cycle pulse
`include "hmr_macros.svh"

module hmr_mode_ctrl import hmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tmr_cfg_u               cfg_i,
  input  logic [`HMR_DATA_W-1:0] store_i,
  input  logic                   store_we_zero_i,
  input  logic                   lead_fetch_en_i,
  input  logic                   cores_synch_i,
  input  logic [2:0]             error_cba_i,
  input  logic                   failure_i,
  output logic [`HMR_MODE_W-1:0] mode_o,
  output logic                   force_ack_o,
  output logic [2:0]             mism_incr_o,
  output logic                   setback_o,
  output logic                   resynch_req_o
);

  logic [`HMR_MODE_W-1:0] mode_d;
  logic [`HMR_MODE_W-1:0] mode_q;
  logic                   setback_d;
  logic                   setback_q;
  logic                   mismatch;

  assign mismatch = |error_cba_i;

  always_comb begin
    mode_d      = mode_q;
    setback_d   = 1'b0;
    force_ack_o = 1'b0;
    mism_incr_o = 3'b000;

    if (mode_q == `HMR_MODE_RUN) begin
      if (cfg_i.f.force_resynch) begin
        force_ack_o = 1'b1;
        if (!cfg_i.f.delay_resynch)
          mode_d = `HMR_MODE_UNLOAD;
      end
      if (mismatch) begin
        mism_incr_o = error_cba_i;
        if (!cfg_i.f.delay_resynch)
          mode_d = `HMR_MODE_UNLOAD;
      end
    end

    // Software has saved its stack pointer
    if (mode_q == `HMR_MODE_UNLOAD && store_i != '0) begin
      mode_d    = `HMR_MODE_RELOAD;
      setback_d = cfg_i.f.setback;
    end

    // Store cleared means the reload finished
    if (mode_q == `HMR_MODE_RELOAD) begin
      if (store_i == '0) begin
        mode_d = `HMR_MODE_RUN;
      end else if ((mismatch || failure_i) && cfg_i.f.setback && cfg_i.f.reload_setback &&
                   !store_we_zero_i && !setback_q) begin
        setback_d = 1'b1;
      end
    end

    // Before startup the mode just follows the enable bit
    if (!lead_fetch_en_i)
      mode_d = cfg_i.f.tmr_enable ? `HMR_MODE_RUN : `HMR_MODE_NON;
    if (mode_q == `HMR_MODE_RUN && !cfg_i.f.tmr_enable)
      mode_d = `HMR_MODE_NON;
    if (mode_q == `HMR_MODE_NON && cores_synch_i && cfg_i.f.tmr_enable)
      mode_d = `HMR_MODE_RUN;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= `HMR_MODE_NON;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o        = mode_q;
  assign setback_o     = setback_q;
  assign resynch_req_o = (mode_q == `HMR_MODE_UNLOAD);

endmodule

// ==== src/hmr_cfg_regs.sv ====
// Word addresses only; writes land at the next edge, reads are combinational, counters wrap
`include "hmr_macros.svh"

module hmr_cfg_regs import hmr_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         reg_we_i,
  input  logic [`HMR_REG_AW-1:0]                       reg_addr_i,
  input  logic [`HMR_DATA_W-1:0]                       reg_wdata_i,
  output logic [`HMR_DATA_W-1:0]                       reg_rdata_o,
  output tmr_cfg_u [`HMR_NUM_GROUPS-1:0]               cfg_o,
  output logic [`HMR_NUM_GROUPS-1:0][`HMR_DATA_W-1:0] store_o,
  output logic [`HMR_NUM_GROUPS-1:0]                   store_we_zero_o,
  input  logic [`HMR_NUM_GROUPS-1:0]                   force_ack_i,
  input  logic [`HMR_NUM_CORES-1:0]                    mism_incr_i
);

  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0] mism;

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_group
    tmr_cfg_u               cfg_q;
    logic [`HMR_DATA_W-1:0] store_q;
    logic                   cfg_we;
    logic                   store_we;

    assign cfg_we   = reg_we_i && (reg_addr_i == `HMR_REG_AW'(`HMR_ADDR_CFG(g)));
    assign store_we = reg_we_i && (reg_addr_i == `HMR_REG_AW'(`HMR_ADDR_STORE(g)));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cfg_q   <= '0;
        store_q <= '0;
      end else begin
        // A new write wins over the FSM clearing force_resynch
        if (cfg_we)
          cfg_q.raw <= reg_wdata_i;
        else if (force_ack_i[g])
          cfg_q.f.force_resynch <= 1'b0;
        if (store_we)
          store_q <= reg_wdata_i;
      end
    end

    assign cfg_o[g]           = cfg_q;
    assign store_o[g]         = store_q;
    assign store_we_zero_o[g] = store_we && (reg_wdata_i == '0);
  end

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_core
    logic [`HMR_DATA_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni)
        cnt_q <= '0;
      else if (mism_incr_i[c])
        cnt_q <= cnt_q + 1'b1;
    end

    assign mism[c] = cnt_q;
  end

  always_comb begin
    reg_rdata_o = '0;
    for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
      if (reg_addr_i == `HMR_REG_AW'(`HMR_ADDR_CFG(g)))
        reg_rdata_o = cfg_o[g].raw;
      if (reg_addr_i == `HMR_REG_AW'(`HMR_ADDR_STORE(g)))
        reg_rdata_o = store_o[g];
    end
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      if (reg_addr_i == `HMR_REG_AW'(`HMR_ADDR_MISM(c)))
        reg_rdata_o = mism[c];
    end
  end

endmodule

// ==== src/hmr_core_router.sv ====
// Combinational; in any redundant mode only the lead slot talks to the system
`include "hmr_macros.svh"

module hmr_core_router import hmr_pkg::*; (
  input  logic [`HMR_NUM_GROUPS-1:0][`HMR_MODE_W-1:0] mode_i,
  // Voted core outputs
  input  logic [`HMR_NUM_GROUPS-1:0]                  vote_busy_i,
  input  logic [`HMR_NUM_GROUPS-1:0]                  vote_instr_req_i,
  input  logic [`HMR_NUM_GROUPS-1:0][`HMR_ADDR_W-1:0] vote_instr_addr_i,
  input  logic [`HMR_NUM_GROUPS-1:0]                  vote_data_req_i,
  input  logic [`HMR_NUM_GROUPS-1:0][`HMR_ADDR_W-1:0] vote_data_addr_i,
  input  logic [`HMR_NUM_GROUPS-1:0]                  vote_data_we_i,
  input  logic [`HMR_NUM_GROUPS-1:0][`HMR_DATA_W-1:0] vote_data_wdata_i,
  // System to core
  input  logic [`HMR_NUM_CORES-1:0]                   sys_fetch_en_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_boot_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   sys_instr_gnt_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_instr_rdata_i,
  input  logic [`HMR_NUM_CORES-1:0]                   sys_data_gnt_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_data_rdata_i,
  output logic [`HMR_NUM_CORES-1:0]                   core_fetch_en_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_boot_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   core_instr_gnt_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_instr_rdata_o,
  output logic [`HMR_NUM_CORES-1:0]                   core_data_gnt_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_data_rdata_o,
  // Core to system
  input  logic [`HMR_NUM_CORES-1:0]                   core_busy_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_instr_req_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_instr_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_data_req_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_data_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_data_we_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_data_wdata_i,
  output logic [`HMR_NUM_CORES-1:0]                   sys_busy_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_instr_req_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_instr_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_data_req_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_data_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_data_we_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_data_wdata_o
);

  localparam int SelW = $clog2(`HMR_NUM_CORES);

  for (genvar i = 0; i < `HMR_NUM_CORES; i++) begin : gen_slot
    localparam int Grp    = group_of(i);
    localparam int Lead   = core_of(Grp, 0);
    localparam bit IsLead = (i == Lead);

    logic            redundant;
    logic [SelW-1:0] src;

    assign redundant = (mode_i[Grp] != `HMR_MODE_NON);
    // All group members follow the lead slot
    assign src = redundant ? SelW'(Lead) : SelW'(i);

    assign core_fetch_en_o[i]    = sys_fetch_en_i[src];
    assign core_boot_addr_o[i]   = sys_boot_addr_i[src];
    assign core_instr_gnt_o[i]   = sys_instr_gnt_i[src];
    assign core_instr_rdata_o[i] = sys_instr_rdata_i[src];
    assign core_data_gnt_o[i]    = sys_data_gnt_i[src];
    assign core_data_rdata_o[i]  = sys_data_rdata_i[src];

    // Lead slot carries the vote, the other two go quiet
    assign sys_busy_o[i]       = !redundant ? core_busy_i[i] :
                                 IsLead ? vote_busy_i[Grp] : '0;
    assign sys_instr_req_o[i]  = !redundant ? core_instr_req_i[i] :
                                 IsLead ? vote_instr_req_i[Grp] : '0;
    assign sys_instr_addr_o[i] = !redundant ? core_instr_addr_i[i] :
                                 IsLead ? vote_instr_addr_i[Grp] : '0;
    assign sys_data_req_o[i]   = !redundant ? core_data_req_i[i] :
                                 IsLead ? vote_data_req_i[Grp] : '0;
    assign sys_data_addr_o[i]  = !redundant ? core_data_addr_i[i] :
                                 IsLead ? vote_data_addr_i[Grp] : '0;
    assign sys_data_we_o[i]    = !redundant ? core_data_we_i[i] :
                                 IsLead ? vote_data_we_i[Grp] : '0;
    assign sys_data_wdata_o[i] = !redundant ? core_data_wdata_i[i] :
                                 IsLead ? vote_data_wdata_i[Grp] : '0;
  end

endmodule

// ==== src/hmr_tmr_top.sv ====
// TMR only, sequential groups; error and failure flags read zero while a group is independent
`include "hmr_macros.svh"

module hmr_tmr_top import hmr_pkg::*; (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        reg_we_i,
  input  logic [`HMR_REG_AW-1:0]                      reg_addr_i,
  input  logic [`HMR_DATA_W-1:0]                      reg_wdata_i,
  output logic [`HMR_DATA_W-1:0]                      reg_rdata_o,
  output logic [`HMR_NUM_GROUPS-1:0]                  tmr_failure_o,
  output logic [`HMR_NUM_CORES-1:0]                   tmr_error_o,
  output logic [`HMR_NUM_GROUPS-1:0]                  tmr_resynch_req_o,
  input  logic [`HMR_NUM_GROUPS-1:0]                  tmr_cores_synch_i,
  output logic [`HMR_NUM_CORES-1:0]                   core_setback_o,
  // System side
  input  logic [`HMR_NUM_CORES-1:0]                   sys_fetch_en_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_boot_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   sys_instr_gnt_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_instr_rdata_i,
  input  logic [`HMR_NUM_CORES-1:0]                   sys_data_gnt_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_data_rdata_i,
  output logic [`HMR_NUM_CORES-1:0]                   sys_busy_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_instr_req_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_instr_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_data_req_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  sys_data_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   sys_data_we_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  sys_data_wdata_o,
  // Core side
  output logic [`HMR_NUM_CORES-1:0]                   core_fetch_en_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_boot_addr_o,
  output logic [`HMR_NUM_CORES-1:0]                   core_instr_gnt_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_instr_rdata_o,
  output logic [`HMR_NUM_CORES-1:0]                   core_data_gnt_o,
  output logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_data_rdata_o,
  input  logic [`HMR_NUM_CORES-1:0]                   core_busy_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_instr_req_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_instr_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_data_req_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_ADDR_W-1:0]  core_data_addr_i,
  input  logic [`HMR_NUM_CORES-1:0]                   core_data_we_i,
  input  logic [`HMR_NUM_CORES-1:0][`HMR_DATA_W-1:0]  core_data_wdata_i
);

  logic [`HMR_NUM_CORES-1:0][`HMR_VOTE_W-1:0]  vote_in;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_VOTE_W-1:0] voted;
  logic [`HMR_NUM_GROUPS-1:0][2:0]             error_cba;
  logic [`HMR_NUM_GROUPS-1:0]                  failure;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_MODE_W-1:0] mode;
  tmr_cfg_u [`HMR_NUM_GROUPS-1:0]              cfg;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_DATA_W-1:0] store;
  logic [`HMR_NUM_GROUPS-1:0]                  store_we_zero;
  logic [`HMR_NUM_GROUPS-1:0]                  force_ack;
  logic [`HMR_NUM_GROUPS-1:0]                  setback;
  logic [`HMR_NUM_GROUPS-1:0][2:0]             mism_incr_grp;
  logic [`HMR_NUM_CORES-1:0]                   mism_incr;

  logic [`HMR_NUM_GROUPS-1:0]                  vote_busy;
  logic [`HMR_NUM_GROUPS-1:0]                  vote_instr_req;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_ADDR_W-1:0] vote_instr_addr;
  logic [`HMR_NUM_GROUPS-1:0]                  vote_data_req;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_ADDR_W-1:0] vote_data_addr;
  logic [`HMR_NUM_GROUPS-1:0]                  vote_data_we;
  logic [`HMR_NUM_GROUPS-1:0][`HMR_DATA_W-1:0] vote_data_wdata;

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_pack
    assign vote_in[c] = {core_busy_i[c], core_instr_req_i[c], core_instr_addr_i[c],
                         core_data_req_i[c], core_data_addr_i[c], core_data_we_i[c],
                         core_data_wdata_i[c]};
  end

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_group
    logic redundant;

    hmr_voter i_voter (
      .a_i        (vote_in[core_of(g, 0)]),
      .b_i        (vote_in[core_of(g, 1)]),
      .c_i        (vote_in[core_of(g, 2)]),
      .majority_o (voted[g]),
      .error_cba_o(error_cba[g]),
      .failure_o  (failure[g])
    );

    assign {vote_busy[g], vote_instr_req[g], vote_instr_addr[g], vote_data_req[g],
            vote_data_addr[g], vote_data_we[g], vote_data_wdata[g]} = voted[g];

    hmr_mode_ctrl i_mode_ctrl (
      .clk_i,
      .rst_ni,
      .cfg_i          (cfg[g]),
      .store_i        (store[g]),
      .store_we_zero_i(store_we_zero[g]),
      .lead_fetch_en_i(sys_fetch_en_i[core_of(g, 0)]),
      .cores_synch_i  (tmr_cores_synch_i[g]),
      .error_cba_i    (error_cba[g]),
      .failure_i      (failure[g]),
      .mode_o         (mode[g]),
      .force_ack_o    (force_ack[g]),
      .mism_incr_o    (mism_incr_grp[g]),
      .setback_o      (setback[g]),
      .resynch_req_o  (tmr_resynch_req_o[g])
    );

    // Independent cores differ on purpose
    assign redundant        = (mode[g] != `HMR_MODE_NON);
    assign tmr_failure_o[g] = failure[g] && redundant;

    for (genvar k = 0; k < 3; k++) begin : gen_member
      assign tmr_error_o[core_of(g, k)]    = error_cba[g][k] && redundant;
      assign mism_incr[core_of(g, k)]      = mism_incr_grp[g][k];
      assign core_setback_o[core_of(g, k)] = setback[g];
    end
  end

  hmr_cfg_regs i_cfg_regs (
    .clk_i,
    .rst_ni,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .cfg_o          (cfg),
    .store_o        (store),
    .store_we_zero_o(store_we_zero),
    .force_ack_i    (force_ack),
    .mism_incr_i    (mism_incr)
  );

  hmr_core_router i_core_router (
    .mode_i           (mode),
    .vote_busy_i      (vote_busy),
    .vote_instr_req_i (vote_instr_req),
    .vote_instr_addr_i(vote_instr_addr),
    .vote_data_req_i  (vote_data_req),
    .vote_data_addr_i (vote_data_addr),
    .vote_data_we_i   (vote_data_we),
    .vote_data_wdata_i(vote_data_wdata),
    .sys_fetch_en_i,
    .sys_boot_addr_i,
    .sys_instr_gnt_i,
    .sys_instr_rdata_i,
    .sys_data_gnt_i,
    .sys_data_rdata_i,
    .core_fetch_en_o,
    .core_boot_addr_o,
    .core_instr_gnt_o,
    .core_instr_rdata_o,
    .core_data_gnt_o,
    .core_data_rdata_o,
    .core_busy_i,
    .core_instr_req_i,
    .core_instr_addr_i,
    .core_data_req_i,
    .core_data_addr_i,
    .core_data_we_i,
    .core_data_wdata_i,
    .sys_busy_o,
    .sys_instr_req_o,
    .sys_instr_addr_o,
    .sys_data_req_o,
    .sys_data_addr_o,
    .sys_data_we_o,
    .sys_data_wdata_o
  );

endmodule

// ==== bench/hmr_props.sv ====
// Bound into every mode FSM instance; only the port names of hmr_mode_ctrl are assumed
`include "hmr_macros.svh"

module hmr_props (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [`HMR_MODE_W-1:0] mode_o,
  input logic                   setback_o,
  input logic                   resynch_req_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Setback is a single-cycle pulse
  setback_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    setback_o |=> !setback_o)
    else $error("setback stayed high for two cycles");

  // Request only rises out of running mode
  resynch_from_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(resynch_req_o) |-> ($past(mode_o) == `HMR_MODE_RUN))
    else $error("resynch request rose outside of running mode");

  // No shortcut out of independent mode into unload
  no_non_to_unload: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_o == `HMR_MODE_NON) |=> (mode_o != `HMR_MODE_UNLOAD))
    else $error("mode jumped from non-redundant to unload");

endmodule

bind hmr_mode_ctrl hmr_props props0 (.*);

// ==== bench/hmr_checker.sv ====
// Reads the DUT ports through the testbench top; expected modes come from the stimulus side
`include "hmr_macros.svh"

module hmr_checker (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input logic [`HMR_NUM_GROUPS-1:0][`HMR_MODE_W-1:0] exp_mode,
  input logic [`HMR_NUM_GROUPS-1:0]                  exp_setback
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int VW = `HMR_VOTE_W;

  int err_cnt = 0;

  function automatic logic [VW-1:0] majority(logic [VW-1:0] a, logic [VW-1:0] b,
                                             logic [VW-1:0] c);
    logic [VW-1:0] m;
    int ones;
    for (int i = 0; i < VW; i++) begin
      ones = int'(a[i]) + int'(b[i]) + int'(c[i]);
      m[i] = (ones >= 2);
    end
    return m;
  endfunction

  // Expected system words of the three slots of one group
  function automatic logic [2:0][VW-1:0] ref_sys(logic [`HMR_MODE_W-1:0] mode,
                                                 logic [VW-1:0] a, logic [VW-1:0] b,
                                                 logic [VW-1:0] c);
    if (mode == `HMR_MODE_NON)
      return {c, b, a};
    return {{VW{1'b0}}, {VW{1'b0}}, majority(a, b, c)};
  endfunction

  task automatic compare(string what, logic [127:0] exp, logic [127:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s %s expected %h actual %h", hmr_tb.test_name, what, exp, act);
    end
  endtask

  always @(posedge clk_i) begin : check
    logic [VW-1:0]      w [3];
    logic [VW-1:0]      maj;
    logic [2:0][VW-1:0] exp_sys;
    logic [VW-1:0]      act_sys;
    logic [98:0]        exp_in;
    logic [98:0]        act_in;
    logic               red;
    int                 slot;
    int                 src;
    if (rst_ni) begin
      for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
        for (int k = 0; k < 3; k++)
          w[k] = hmr_tb.core_word[3 * g + k];
        red     = (exp_mode[g] != `HMR_MODE_NON);
        maj     = majority(w[0], w[1], w[2]);
        exp_sys = ref_sys(exp_mode[g], w[0], w[1], w[2]);
        for (int k = 0; k < 3; k++) begin
          slot    = 3 * g + k;
          src     = red ? 3 * g : slot;
          act_sys = {hmr_tb.sys_busy_o[slot], hmr_tb.sys_instr_req_o[slot],
                     hmr_tb.sys_instr_addr_o[slot], hmr_tb.sys_data_req_o[slot],
                     hmr_tb.sys_data_addr_o[slot], hmr_tb.sys_data_we_o[slot],
                     hmr_tb.sys_data_wdata_o[slot]};
          compare($sformatf("sys_word[%0d]", slot), 128'(exp_sys[k]), 128'(act_sys));
          exp_in = {hmr_tb.sys_fetch_en_i[src], hmr_tb.sys_boot_addr_i[src],
                    hmr_tb.sys_instr_gnt_i[src], hmr_tb.sys_instr_rdata_i[src],
                    hmr_tb.sys_data_gnt_i[src], hmr_tb.sys_data_rdata_i[src]};
          act_in = {hmr_tb.core_fetch_en_o[slot], hmr_tb.core_boot_addr_o[slot],
                    hmr_tb.core_instr_gnt_o[slot], hmr_tb.core_instr_rdata_o[slot],
                    hmr_tb.core_data_gnt_o[slot], hmr_tb.core_data_rdata_o[slot]};
          compare($sformatf("core_in[%0d]", slot), 128'(exp_in), 128'(act_in));
          compare($sformatf("tmr_error[%0d]", slot), 128'(red && (w[k] != maj)),
                  128'(hmr_tb.tmr_error_o[slot]));
          compare($sformatf("setback[%0d]", slot), 128'(exp_setback[g]),
                  128'(hmr_tb.core_setback_o[slot]));
        end
        compare($sformatf("failure[%0d]", g),
                128'(red && w[0] != w[1] && w[1] != w[2] && w[0] != w[2]),
                128'(hmr_tb.tmr_failure_o[g]));
        compare($sformatf("resynch_req[%0d]", g),
                128'(exp_mode[g] == `HMR_MODE_UNLOAD), 128'(hmr_tb.tmr_resynch_req_o[g]));
      end
    end
  end

endmodule

// ==== bench/hmr_tb.sv ====
// Group 0 walks through the TMR sequence while group 1 stays independent with random cores
`include "hmr_macros.svh"

module hmr_tb import hmr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxCycles = 2000;
  localparam int VW        = `HMR_VOTE_W;
  localparam int C         = `HMR_NUM_CORES;
  localparam int G         = `HMR_NUM_GROUPS;
  // Group 0 core word patterns
  localparam int Agree  = 0;
  localparam int Triple = 4;
  localparam int Indep  = 5;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          reg_we_i;
  logic [`HMR_REG_AW-1:0]        reg_addr_i;
  logic [`HMR_DATA_W-1:0]        reg_wdata_i;
  logic [`HMR_DATA_W-1:0]        reg_rdata_o;
  logic [G-1:0]                  tmr_failure_o;
  logic [C-1:0]                  tmr_error_o;
  logic [G-1:0]                  tmr_resynch_req_o;
  logic [G-1:0]                  tmr_cores_synch_i;
  logic [C-1:0]                  core_setback_o;
  logic [C-1:0]                  sys_fetch_en_i;
  logic [C-1:0][`HMR_ADDR_W-1:0] sys_boot_addr_i;
  logic [C-1:0]                  sys_instr_gnt_i;
  logic [C-1:0][`HMR_DATA_W-1:0] sys_instr_rdata_i;
  logic [C-1:0]                  sys_data_gnt_i;
  logic [C-1:0][`HMR_DATA_W-1:0] sys_data_rdata_i;
  logic [C-1:0]                  sys_busy_o;
  logic [C-1:0]                  sys_instr_req_o;
  logic [C-1:0][`HMR_ADDR_W-1:0] sys_instr_addr_o;
  logic [C-1:0]                  sys_data_req_o;
  logic [C-1:0][`HMR_ADDR_W-1:0] sys_data_addr_o;
  logic [C-1:0]                  sys_data_we_o;
  logic [C-1:0][`HMR_DATA_W-1:0] sys_data_wdata_o;
  logic [C-1:0]                  core_fetch_en_o;
  logic [C-1:0][`HMR_ADDR_W-1:0] core_boot_addr_o;
  logic [C-1:0]                  core_instr_gnt_o;
  logic [C-1:0][`HMR_DATA_W-1:0] core_instr_rdata_o;
  logic [C-1:0]                  core_data_gnt_o;
  logic [C-1:0][`HMR_DATA_W-1:0] core_data_rdata_o;
  logic [C-1:0]                  core_busy_i;
  logic [C-1:0]                  core_instr_req_i;
  logic [C-1:0][`HMR_ADDR_W-1:0] core_instr_addr_i;
  logic [C-1:0]                  core_data_req_i;
  logic [C-1:0][`HMR_ADDR_W-1:0] core_data_addr_i;
  logic [C-1:0]                  core_data_we_i;
  logic [C-1:0][`HMR_DATA_W-1:0] core_data_wdata_i;

  logic [C-1:0][VW-1:0]             core_word;
  logic [G-1:0][`HMR_MODE_W-1:0]    exp_mode;
  logic [G-1:0]                     exp_setback;
  integer                           seed = 32'h731918c8;
  int                               cycles = 0;
  int                               rd_errs = 0;
  int                               fault;
  string                            test_name;

  for (genvar c = 0; c < C; c++) begin : gen_core
    assign {core_busy_i[c], core_instr_req_i[c], core_instr_addr_i[c], core_data_req_i[c],
            core_data_addr_i[c], core_data_we_i[c], core_data_wdata_i[c]} = core_word[c];
  end

  hmr_tmr_top dut0 (.*);

  hmr_checker chk0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .exp_mode   (exp_mode),
    .exp_setback(exp_setback)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // One falling edge with fresh random core words and system inputs
  task automatic next_cycle();
    logic [127:0]  r;
    logic [VW-1:0] base;
    int            idx;
    @(negedge clk_i);
    for (int c = 0; c < C; c++) begin
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      core_word[c] = r[VW-1:0];
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      sys_boot_addr_i[c]   = r[31:0];
      sys_instr_rdata_i[c] = r[63:32];
      sys_data_rdata_i[c]  = r[95:64];
      sys_instr_gnt_i[c]   = r[96];
      sys_data_gnt_i[c]    = r[97];
    end
    if (fault != Indep) begin
      base = core_word[0];
      idx  = $unsigned($random(seed)) % VW;
      for (int k = 0; k < 3; k++)
        core_word[core_of(0, k)] = base;
      if (fault >= 1 && fault <= 3)
        core_word[fault - 1][idx] = ~base[idx];
      if (fault == Triple) begin
        core_word[1][idx]            = ~base[idx];
        core_word[2][(idx + 1) % VW] = ~base[(idx + 1) % VW];
      end
    end
  endtask

  task automatic reg_write(int addr, logic [31:0] data);
    next_cycle();
    reg_we_i    = 1'b1;
    reg_addr_i  = `HMR_REG_AW'(addr);
    reg_wdata_i = data;
    next_cycle();
    reg_we_i = 1'b0;
  endtask

  task automatic reg_expect(int addr, logic [31:0] exp);
    next_cycle();
    reg_addr_i = `HMR_REG_AW'(addr);
    #1;
    if (reg_rdata_o !== exp) begin
      rd_errs++;
      $display("ERR %s reg[%0d] expected %h actual %h", test_name, addr, exp, reg_rdata_o);
    end
  endtask

  initial begin
    logic [31:0] v;
    rst_ni = 1'b0;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    tmr_cores_synch_i = '0;
    sys_fetch_en_i = '0;
    sys_boot_addr_i = '0;
    sys_instr_gnt_i = '0;
    sys_instr_rdata_i = '0;
    sys_data_gnt_i = '0;
    sys_data_rdata_i = '0;
    core_word = '0;
    exp_mode = '0;
    exp_setback = '0;
    fault = Indep;
    test_name = "reset";
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "independent";
    repeat (30) begin
      next_cycle();
      sys_fetch_en_i = `HMR_NUM_CORES'($random(seed));
    end

    test_name = "readback";
    sys_fetch_en_i = '0;
    for (int g = 0; g < G; g++) begin
      v = $random(seed) & 32'hffff_fffe;
      reg_write(`HMR_ADDR_CFG(g), v);
      reg_expect(`HMR_ADDR_CFG(g), v);
      v = $random(seed);
      reg_write(`HMR_ADDR_STORE(g), v);
      reg_expect(`HMR_ADDR_STORE(g), v);
      reg_write(`HMR_ADDR_STORE(g), 32'h0);
      reg_write(`HMR_ADDR_CFG(g), 32'h0);
    end

    test_name = "voted_run";
    fault = Agree;
    reg_write(`HMR_ADDR_CFG(0), 32'h1);
    next_cycle();
    exp_mode[0] = `HMR_MODE_RUN;
    sys_fetch_en_i[0] = 1'b1;
    repeat (20) next_cycle();

    // Delayed resynch so the forced request is taken without leaving RUN
    test_name = "force_ack";
    reg_write(`HMR_ADDR_CFG(0), 32'h13);
    reg_expect(`HMR_ADDR_CFG(0), 32'h03);
    reg_write(`HMR_ADDR_CFG(0), 32'h05);
    repeat (3) next_cycle();

    test_name = "single_fault";
    fault = 2;
    next_cycle();
    fault = Agree;
    next_cycle();
    exp_mode[0] = `HMR_MODE_UNLOAD;
    reg_expect(`HMR_ADDR_MISM(1), 32'd1);
    reg_expect(`HMR_ADDR_MISM(0), 32'd0);

    test_name = "recovery";
    reg_write(`HMR_ADDR_STORE(0), 32'h8000_1000);
    next_cycle();
    exp_mode[0] = `HMR_MODE_RELOAD;
    exp_setback[0] = 1'b1;
    next_cycle();
    exp_setback[0] = 1'b0;
    repeat (3) next_cycle();
    reg_write(`HMR_ADDR_STORE(0), 32'h0);
    next_cycle();
    exp_mode[0] = `HMR_MODE_RUN;
    reg_expect(`HMR_ADDR_STORE(0), 32'h0);
    repeat (3) next_cycle();

    test_name = "triple";
    fault = Triple;
    next_cycle();
    fault = Agree;
    next_cycle();
    exp_mode[0] = `HMR_MODE_UNLOAD;
    repeat (5) next_cycle();

    $display("Errors: %0d output, %0d register read-back", chk0.err_cnt, rd_errs);
    if (chk0.err_cnt == 0 && rd_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/hmr_pkg.sv
src/hmr_tmr_voter.sv
src/hmr_mode_ctrl.sv
src/hmr_cfg_regs.sv
src/hmr_core_router.sv
src/hmr_tmr_top.sv
bench/hmr_props.sv
bench/hmr_checker.sv
bench/hmr_tb.sv

// ==== Makefile ====
TOP = hmr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
